/* hdl/ex_pkg.sv */
/*
 * Execute stage datapath definitions
 * Operand width, register file address type and the ALU operator set
 */

package ex_pkg;

  // Datapath and register file widths
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 6;

  // Operand and result word
  typedef logic [DATA_W-1:0] data_t;

  // Register file address, includes the extra bank bit
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ALU operators
  // Arithmetic and logic first, then shifts, set-less-than and branch compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

endpackage

/* hdl/mult_pkg.sv */
/*
 * Multiplier definitions
 * Operator set, shift-add step count and sequencer states
 */

package mult_pkg;

  // MUL is single cycle, the three high variants are iterative
  typedef enum logic [1:0] {
    MUL    = 2'b00,
    MULH   = 2'b01,
    MULHSU = 2'b10,
    MULHU  = 2'b11
  } mult_op_e;

  // One shift-add step per multiplier bit
  localparam int MULT_ITERS = 32;

  // Step counter
  typedef logic [5:0] iter_cnt_t;

  // High multiply sequencer
  typedef enum logic [1:0] {
    MULT_IDLE = 2'b00,
    MULT_STEP = 2'b01,
    MULT_DONE = 2'b10
  } mult_state_e;

endpackage

/* hdl/ex_alu.sv */
/*
 * Execute stage ALU
 * Purely combinational add, subtract, logic, shift and compare unit
 * Also produces the compare bit used for branch decisions
 */

`timescale 1ns/1ns

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            cmp_result_o
);

  import ex_pkg::*;

  // Shift amount from the low five bits of operand b
  logic [4:0] shamt;

  // Shared compare terms
  logic       is_equal;
  logic       less_signed;
  logic       less_unsigned;

  // Selected compare bit
  logic       cmp_bit;

  assign shamt = operand_b_i[4:0];

  //////////////////////////////
  // Comparator
  //////////////////////////////

  assign is_equal      = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  always_comb begin
    cmp_bit = 1'b0;
    case (operator_i)
      // Set-less-than shares the branch compare logic
      ALU_SLT:  cmp_bit = less_signed;
      ALU_SLTU: cmp_bit = less_unsigned;
      // Branch compares
      ALU_EQ:   cmp_bit = is_equal;
      ALU_NE:   cmp_bit = ~is_equal;
      ALU_LT:   cmp_bit = less_signed;
      ALU_GE:   cmp_bit = ~less_signed;
      ALU_LTU:  cmp_bit = less_unsigned;
      ALU_GEU:  cmp_bit = ~less_unsigned;
      default:  cmp_bit = 1'b0;
    endcase
  end

  // Zero for arithmetic, logic and shift operators
  assign cmp_result_o = cmp_bit;

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    // Compare operators return the bit zero-extended
    result_o = {{(DATA_W-1){1'b0}}, cmp_bit};
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      // Logical shifts fill with zeros
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA: result_o = data_t'($signed(operand_a_i) >>> shamt);
      default: result_o = {{(DATA_W-1){1'b0}}, cmp_bit};
    endcase
  end

endmodule

/* hdl/ex_mult.sv */
/*
 * Execute stage multiplier
 * MUL returns the low product word in the same cycle
 * MULH, MULHSU and MULHU run a shift-add sequencer and stall the stage
 */

`timescale 1ns/1ns

module ex_mult (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable_i,
  input  mult_pkg::mult_op_e operator_i,
  input  ex_pkg::data_t      op_a_i,
  input  ex_pkg::data_t      op_b_i,
  input  logic               ex_ready_i,
  output ex_pkg::data_t      result_o,
  output logic               multicycle_o,
  output logic               ready_o
);

  import ex_pkg::*;
  import mult_pkg::*;

  // Sequencer control
  mult_state_e state_q;
  mult_state_e state_d;
  iter_cnt_t   cnt_q;
  logic        last_step;

  // Operator decode
  logic        is_high;
  logic        a_signed;
  logic        b_signed;

  // Shift-add datapath, double width
  logic [2*DATA_W-1:0] acc_q;
  logic [2*DATA_W-1:0] mcand_q;
  data_t               mplier_q;

  // Single cycle low product
  data_t               prod_lo;

  assign is_high  = (operator_i != MUL);
  assign a_signed = (operator_i == MULH) || (operator_i == MULHSU);
  assign b_signed = (operator_i == MULH);

  assign prod_lo  = op_a_i * op_b_i;

  assign last_step = (cnt_q == iter_cnt_t'(MULT_ITERS - 1));

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Leave IDLE on the first presented high multiply
      MULT_IDLE: if (enable_i && is_high) state_d = MULT_STEP;
      MULT_STEP: if (last_step) state_d = MULT_DONE;
      // Hold the result until the stage hands it on
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MULT_STEP) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  //////////////////////////////
  // Shift-add datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE) begin
      // Load with operand a extended per operator
      acc_q    <= '0;
      mcand_q  <= {{DATA_W{a_signed & op_a_i[DATA_W-1]}}, op_a_i};
      mplier_q <= op_b_i;
    end else if (state_q == MULT_STEP) begin
      if (mplier_q[0]) begin
        // Signed b gives its top bit a negative weight
        if (last_step && b_signed) begin
          acc_q <= acc_q - mcand_q;
        end else begin
          acc_q <= acc_q + mcand_q;
        end
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Upper product word for the high variants
  assign result_o = is_high ? acc_q[2*DATA_W-1:DATA_W] : prod_lo;

  assign multicycle_o = (state_q == MULT_STEP);

  always_comb begin
    case (state_q)
      MULT_IDLE: ready_o = ~(enable_i & is_high);
      MULT_DONE: ready_o = 1'b1;
      default:   ready_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // ID must hold the operator for the whole sequence
  a_op_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != MULT_IDLE) |-> $stable(operator_i));

  // Counter stays inside the step range
  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MULT_STEP) |-> (cnt_q < MULT_ITERS));

endmodule

/* hdl/ex_wb_ctrl.sv */
/*
 * Execute stage write-back control
 * ALU/forwarding write port, EX/WB register with the load write port,
 * and the stage ready/valid handshake
 */

`timescale 1ns/1ns

module ex_wb_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  ex_pkg::data_t     alu_result_i,
  input  ex_pkg::data_t     mult_result_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  // Load write enable with bus errors masked
  logic lsu_we;

  assign lsu_we = regfile_we_i & ~lsu_err_i;

  //////////////////////////////
  // Forwarding write port
  //////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Later sources win so CSR has top priority
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i)     regfile_alu_wdata_fw_o = alu_result_i;
    if (mult_en_i)    regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= lsu_we;
      // Address only moves for a real write
      if (lsu_we) regfile_waddr_wb_o <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      // Nothing new arrived so the slot drains
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Load data comes straight from the LSU in the WB cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Branches resolve in EX and need no WB slot
  assign ex_ready_o = (mult_ready_i & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // A stalled WB stage never takes a new result
  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> ($stable(regfile_we_wb_o) && $stable(regfile_waddr_wb_o)));

endmodule

/* hdl/ex_stage.sv */
/*
 * Execute stage top level
 * Connects the ALU, the multiplier and the write-back control
 */

`timescale 1ns/1ns

module ex_stage (
  input  logic               clk,
  input  logic               rst_n,

  // ALU operands from ID
  input  ex_pkg::alu_op_e    alu_operator_i,
  input  ex_pkg::data_t      alu_operand_a_i,
  input  ex_pkg::data_t      alu_operand_b_i,
  input  ex_pkg::data_t      alu_operand_c_i,
  input  logic               alu_en_i,

  // Multiplier operands from ID
  input  mult_pkg::mult_op_e mult_operator_i,
  input  ex_pkg::data_t      mult_operand_a_i,
  input  ex_pkg::data_t      mult_operand_b_i,
  input  logic               mult_en_i,
  output logic               mult_multicycle_o,

  // CSR and LSU
  input  logic               csr_access_i,
  input  ex_pkg::data_t      csr_rdata_i,
  input  logic               lsu_en_i,
  input  ex_pkg::data_t      lsu_rdata_i,
  input  logic               lsu_ready_ex_i,
  input  logic               lsu_err_i,

  // Register file write requests
  input  logic               regfile_alu_we_i,
  input  ex_pkg::reg_addr_t  regfile_alu_waddr_i,
  input  logic               regfile_we_i,
  input  ex_pkg::reg_addr_t  regfile_waddr_i,
  input  logic               branch_in_ex_i,

  // Forwarding port
  output logic               regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t  regfile_alu_waddr_fw_o,
  output ex_pkg::data_t      regfile_alu_wdata_fw_o,

  // Load write port
  output logic               regfile_we_wb_o,
  output ex_pkg::reg_addr_t  regfile_waddr_wb_o,
  output ex_pkg::data_t      regfile_wdata_wb_o,

  // Branch outputs to IF
  output ex_pkg::data_t      jump_target_o,
  output logic               branch_decision_o,

  // Stage handshake
  input  logic               wb_ready_i,
  output logic               ex_ready_o,
  output logic               ex_valid_o
);

  import ex_pkg::*;

  data_t alu_result;
  logic  alu_cmp;
  data_t mult_result;
  logic  mult_ready;

  // Target is computed in ID, decision from the ALU compare
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp;

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_wb_ctrl u_wb_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

/* tests/ex_stage_ref.svh */
/*
 * Execute stage reference model
 * Expected ALU result, branch compare bit, multiplier result and the LCG
 */

`ifndef EX_STAGE_REF_SVH
`define EX_STAGE_REF_SVH

// Compare bit for the set-less-than and branch operators
function automatic logic cmp_ref(input alu_op_e op, input data_t a, input data_t b);
  logic ltu;
  logic lts;
  ltu = (a < b);
  // Different signs decide on the sign of a alone
  lts = (a[31] != b[31]) ? a[31] : ltu;
  case (op)
    ALU_SLT, ALU_LT:   return lts;
    ALU_SLTU, ALU_LTU: return ltu;
    ALU_GE:            return !lts;
    ALU_GEU:           return !ltu;
    ALU_EQ:            return (a == b);
    ALU_NE:            return (a != b);
    default:           return 1'b0;
  endcase
endfunction

function automatic data_t alu_ref(input alu_op_e op, input data_t a, input data_t b);
  int    sh;
  data_t sra;
  sh  = int'(b[4:0]);
  // Arithmetic shift as a logical shift plus a sign fill
  sra = a >> sh;
  if (a[31]) sra = sra | ~(32'hffff_ffff >> sh);
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << sh;
    ALU_SRL: return a >> sh;
    ALU_SRA: return sra;
    default: return {31'b0, cmp_ref(op, a, b)};
  endcase
endfunction

// Extension is exact modulo 2^64, so a 64-bit product holds the upper word
function automatic data_t mult_ref(input mult_op_e op, input data_t a, input data_t b);
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] prod;
  ea   = {{32{a[31] && (op != MULHU)}}, a};
  eb   = {{32{b[31] && (op == MULH)}}, b};
  prod = ea * eb;
  return (op == MUL) ? prod[31:0] : prod[63:32];
endfunction

// Numerical Recipes constants
function automatic logic [31:0] lcg_step(input logic [31:0] x);
  return x * 32'd1664525 + 32'd1013904223;
endfunction

`endif

/* tests/tb_ex_stage.sv */
/*
 * Execute stage testbench
 * Random ALU, branch, multiply and load traffic checked against a reference model
 */

`timescale 1ns/1ns

module tb_ex_stage;

  import ex_pkg::*;
  import mult_pkg::*;

  `include "ex_stage_ref.svh"

  localparam int RESET_CYCLES = 10;
  localparam int N_ALU  = 200;
  localparam int N_BR   = 40;
  localparam int N_MUL  = 20;
  localparam int N_HMUL = 20;
  localparam int N_LOAD = 12;
  // Twice the expected run, a high multiply costs its latency plus the issue cycle
  localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + N_ALU + N_BR + N_MUL
                                    + N_HMUL * (MULT_ITERS + 2) + 3 * N_LOAD + 100);

  logic      clk = 1'b0;
  logic      rst_n;
  alu_op_e   alu_operator_i;
  data_t     alu_operand_a_i;
  data_t     alu_operand_b_i;
  data_t     alu_operand_c_i;
  logic      alu_en_i;
  mult_op_e  mult_operator_i;
  data_t     mult_operand_a_i;
  data_t     mult_operand_b_i;
  logic      mult_en_i;
  logic      mult_multicycle_o;
  logic      csr_access_i;
  data_t     csr_rdata_i;
  logic      lsu_en_i;
  data_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      branch_in_ex_i;
  logic      regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  data_t     regfile_alu_wdata_fw_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  data_t     regfile_wdata_wb_o;
  data_t     jump_target_o;
  logic      branch_decision_o;
  logic      wb_ready_i;
  logic      ex_ready_o;
  logic      ex_valid_o;

  // Expected forwarding data for the compare process
  data_t       exp_fw;
  string       fw_name;
  logic        fw_chk = 1'b0;
  logic [31:0] seed = 32'h2bd8666f;
  int          cycle_cnt = 0;

  ex_stage u_dut (.*);

  always #10 clk = ~clk;

  //////////////////////////////
  // Checking
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // Forwarding data is compared whenever the stage hands a result on
  always @(negedge clk) begin
    if (fw_chk && ex_valid_o) begin
      check_val(fw_name, exp_fw, regfile_alu_wdata_fw_o);
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the stage stopped making progress", cycle_cnt);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = lcg_step(seed);
    return seed;
  endfunction

  // Inputs change 2 ns after the rising edge
  task automatic to_drive_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_inputs();
    alu_en_i         = 1'b0;
    mult_en_i        = 1'b0;
    csr_access_i     = 1'b0;
    lsu_en_i         = 1'b0;
    lsu_err_i        = 1'b0;
    regfile_alu_we_i = 1'b0;
    regfile_we_i     = 1'b0;
    branch_in_ex_i   = 1'b0;
    lsu_ready_ex_i   = 1'b1;
    wb_ready_i       = 1'b1;
    fw_chk           = 1'b0;
  endtask

  // Counts cycles until ex_ready, and how many of them the multiplier was busy
  task automatic wait_ready(output int cycles, output int busy);
    cycles = 0;
    busy   = 0;
    @(negedge clk);
    while (!ex_ready_o) begin
      if (mult_multicycle_o) busy++;
      cycles++;
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic alu_sweep();
    logic [31:0] r;
    for (int i = 0; i < N_ALU; i++) begin
      to_drive_slot();
      r = next_rand();
      clear_inputs();
      alu_operator_i      = alu_op_e'(r[31:28]);
      alu_operand_a_i     = next_rand();
      // Equal operands now and then for the EQ/NE paths
      alu_operand_b_i     = (r[27:26] == 2'b00) ? alu_operand_a_i : next_rand();
      alu_en_i            = 1'b1;
      regfile_alu_we_i    = r[25];
      regfile_alu_waddr_i = r[24:19];
      exp_fw  = alu_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      fw_name = "alu fw data";
      fw_chk  = 1'b1;
      @(negedge clk);
      check_val("alu fw we", 32'(r[25]), 32'(regfile_alu_we_fw_o));
      check_val("alu fw waddr", 32'(r[24:19]), 32'(regfile_alu_waddr_fw_o));
      check_val("alu ex_valid", 1, 32'(ex_valid_o));
    end
  endtask

  task automatic branch_sweep();
    logic [31:0] r;
    for (int i = 0; i < N_BR; i++) begin
      to_drive_slot();
      r = next_rand();
      clear_inputs();
      // EQ through GEU are the six codes from 4'ha up
      alu_operator_i  = alu_op_e'(4'ha + (r[31:28] % 4'd6));
      alu_operand_a_i = next_rand();
      alu_operand_b_i = (r[27:26] == 2'b00) ? alu_operand_a_i : next_rand();
      alu_operand_c_i = next_rand();
      branch_in_ex_i  = 1'b1;
      // Branch readiness must not wait for WB
      wb_ready_i      = r[20];
      @(negedge clk);
      check_val("branch decision",
                32'(cmp_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i)),
                32'(branch_decision_o));
      check_val("branch target", alu_operand_c_i, jump_target_o);
      check_val("branch ex_ready", 1, 32'(ex_ready_o));
    end
  endtask

  task automatic multiply_sweep();
    logic [31:0] r;
    int          cycles;
    int          busy;
    for (int i = 0; i < N_MUL + N_HMUL; i++) begin
      to_drive_slot();
      r = next_rand();
      clear_inputs();
      mult_operator_i  = (i < N_MUL) ? MUL : mult_op_e'(2'd1 + (r[31:30] % 2'd3));
      mult_operand_a_i = next_rand();
      mult_operand_b_i = next_rand();
      mult_en_i        = 1'b1;
      exp_fw  = mult_ref(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
      fw_name = "mult fw data";
      fw_chk  = 1'b1;
      wait_ready(cycles, busy);
      check_val("mult ex_valid", 1, 32'(ex_valid_o));
      if (i < N_MUL) begin
        check_val("mul wait cycles", 0, cycles);
      end else begin
        check_val("high mult latency", MULT_ITERS + 1, cycles);
        check_val("high mult busy cycles", MULT_ITERS, busy);
      end
    end
  endtask

  // CSR beats both units, the multiplier beats the ALU
  task automatic priority_cases();
    for (int k = 0; k < 6; k++) begin
      to_drive_slot();
      clear_inputs();
      alu_operator_i   = ALU_XOR;
      alu_operand_a_i  = next_rand();
      alu_operand_b_i  = next_rand();
      mult_operator_i  = MUL;
      mult_operand_a_i = next_rand();
      mult_operand_b_i = next_rand();
      csr_rdata_i      = next_rand();
      alu_en_i         = (k % 3 != 1);
      mult_en_i        = (k % 3 != 0);
      csr_access_i     = (k % 3 != 2);
      exp_fw  = csr_access_i ? csr_rdata_i : mult_ref(MUL, mult_operand_a_i, mult_operand_b_i);
      fw_name = "priority fw data";
      fw_chk  = 1'b1;
      @(negedge clk);
      check_val("priority ex_valid", 1, 32'(ex_valid_o));
    end
  endtask

  task automatic load_port();
    logic [31:0] r;
    reg_addr_t   addr;
    logic        err;
    for (int i = 0; i < N_LOAD; i++) begin
      to_drive_slot();
      r = next_rand();
      clear_inputs();
      addr            = r[31:26];
      err             = (r[25:24] == 2'b00);
      lsu_en_i        = 1'b1;
      regfile_we_i    = 1'b1;
      regfile_waddr_i = addr;
      lsu_err_i       = err;
      @(negedge clk);
      check_val("load ex_valid", 1, 32'(ex_valid_o));
      // WB cycle, load data arrives from the LSU
      to_drive_slot();
      clear_inputs();
      lsu_rdata_i = next_rand();
      @(negedge clk);
      check_val("load we_wb", 32'(!err), 32'(regfile_we_wb_o));
      if (!err) begin
        check_val("load waddr_wb", 32'(addr), 32'(regfile_waddr_wb_o));
        check_val("load wdata_wb", lsu_rdata_i, regfile_wdata_wb_o);
      end
    end
    // One load lands in WB, then WB stalls while the next load waits
    to_drive_slot();
    clear_inputs();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = 6'h2a;
    to_drive_slot();
    regfile_waddr_i = 6'h15;
    wb_ready_i      = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_val("stall ex_ready", 0, 32'(ex_ready_o));
      check_val("stall ex_valid", 0, 32'(ex_valid_o));
      check_val("stall we_wb", 1, 32'(regfile_we_wb_o));
      check_val("stall waddr_wb", 32'h2a, 32'(regfile_waddr_wb_o));
      to_drive_slot();
    end
    wb_ready_i = 1'b1;
    @(negedge clk);
    check_val("release ex_valid", 1, 32'(ex_valid_o));
    to_drive_slot();
    clear_inputs();
    @(negedge clk);
    check_val("release waddr_wb", 32'h15, 32'(regfile_waddr_wb_o));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n               = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operator_i     = MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_rdata_i         = '0;
    lsu_rdata_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    clear_inputs();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_val("reset we_wb", 0, 32'(regfile_we_wb_o));
    check_val("reset multicycle", 0, 32'(mult_multicycle_o));
    alu_sweep();
    branch_sweep();
    multiply_sweep();
    priority_cases();
    load_port();
    to_drive_slot();
    clear_inputs();
    @(negedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* ex_stage.f */
+incdir+tests
hdl/ex_pkg.sv
hdl/mult_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_ctrl.sv
hdl/ex_stage.sv
tests/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
  -f ex_stage.f -o sim_ex_stage

out=$(./obj_dir/sim_ex_stage || true)
echo "$out"

if echo "$out" | grep -qF "=== PASS ==="; then
  exit 0
else
  exit 1
fi
